/* hdl/axi_bridge_params.svh */
`ifndef AXI_BRIDGE_PARAMS_SVH
`define AXI_BRIDGE_PARAMS_SVH

// bus widths
`define AXI_ADDR_W  32
`define AXI_DATA_W  32
`define AXI_STRB_W  (`AXI_DATA_W / 8)   // one strobe per byte lane
`define AXI_ID_W    4
`define AXI_SIZE_W  3
`define AXI_RESP_W  2

// sram side size field, 0/1/2 for 1/2/4 bytes
`define SRAM_SIZE_W 2

// read ids, also select the response buffer
`define ID_INST     0
`define ID_DATA     1

`endif

/* hdl/axi_bridge_pkg.sv */
`default_nettype none
`include "axi_bridge_params.svh"

package axi_bridge_pkg;

    //////////////////////////////
    // sram side

    typedef struct packed {
        logic                    wr;      // 1 write, 0 read
        logic [`SRAM_SIZE_W-1:0] size;
        logic [`AXI_ADDR_W-1:0]  addr;
        logic [`AXI_STRB_W-1:0]  wstrb;
        logic [`AXI_DATA_W-1:0]  wdata;
    } sram_req_t;

    //////////////////////////////
    // granted commands

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_SIZE_W-1:0] size;
    } rd_cmd_t;

    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_SIZE_W-1:0] size;
        logic [`AXI_STRB_W-1:0] wstrb;
        logic [`AXI_DATA_W-1:0] wdata;
    } wr_cmd_t;

    //////////////////////////////
    // axi channel payloads

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_SIZE_W-1:0] size;
    } axi_ar_t;

    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_SIZE_W-1:0] size;
    } axi_aw_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_STRB_W-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_RESP_W-1:0] resp;
    } axi_r_t;

    typedef struct packed {
        logic [`AXI_RESP_W-1:0] resp;
    } axi_b_t;

    // completed read, read engine to router
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
    } rd_resp_t;

endpackage

`default_nettype wire

/* hdl/sram_req_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_bridge_params.svh"

module sram_req_arbiter
    import axi_bridge_pkg::*;
(
    input  wire                   aclk,
    input  wire                   aresetn,
    input  wire                   inst_req,
    input  wire sram_req_t        inst_req_info,
    input  wire                   data_req,
    input  wire sram_req_t        data_req_info,
    input  wire                   rd_idle,
    input  wire                   wr_idle,
    input  wire [`AXI_ADDR_W-1:0] wr_pend_addr,
    output rd_cmd_t               rd_cmd,
    output logic                  rd_cmd_valid,
    output wr_cmd_t               wr_cmd,
    output logic                  wr_cmd_valid,
    output logic                  inst_addr_ok,
    output logic                  data_addr_ok
);

    logic data_rd;
    logic inst_hit;
    logic data_hit;
    logic inst_go;
    logic data_go;
    logic pick_data;
    logic wr_acc;
    logic rd_acc;
    logic data_turn;   // data read was passed over once

    //////////////////////////////
    // decode

    // instruction port is read only, its wr/wstrb/wdata are ignored
    assign data_rd      = data_req && !data_req_info.wr;
    assign wr_cmd_valid = data_req && data_req_info.wr;

    assign wr_cmd.addr  = data_req_info.addr;
    assign wr_cmd.size  = `AXI_SIZE_W'(data_req_info.size);
    assign wr_cmd.wstrb = data_req_info.wstrb;
    assign wr_cmd.wdata = data_req_info.wdata;

    assign wr_acc = wr_cmd_valid && wr_idle;

    // read after write, also against a write taken this very cycle
    assign inst_hit = (!wr_idle && wr_pend_addr == inst_req_info.addr)
                   || (wr_acc && data_req_info.addr == inst_req_info.addr);
    assign data_hit = !wr_idle && wr_pend_addr == data_req_info.addr;

    assign inst_go = inst_req && !inst_hit;
    assign data_go = data_rd && !data_hit;

    //////////////////////////////
    // read grant

    // inst first unless the data read already lost one round
    assign pick_data    = data_go && (!inst_go || data_turn);
    assign rd_cmd_valid = inst_go || data_go;
    assign rd_acc       = rd_cmd_valid && rd_idle;

    always_comb begin
        if (pick_data) begin
            rd_cmd.id   = `AXI_ID_W'(`ID_DATA);
            rd_cmd.addr = data_req_info.addr;
            rd_cmd.size = `AXI_SIZE_W'(data_req_info.size);
        end else begin
            rd_cmd.id   = `AXI_ID_W'(`ID_INST);
            rd_cmd.addr = inst_req_info.addr;
            rd_cmd.size = `AXI_SIZE_W'(inst_req_info.size);
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            data_turn <= 1'b0;
        end else if (rd_acc) begin
            data_turn <= !pick_data && data_go;   // cleared once data wins
        end
    end

    assign inst_addr_ok = rd_acc && !pick_data;
    assign data_addr_ok = (rd_acc && pick_data) || wr_acc;

endmodule

`default_nettype wire

/* hdl/axi_read_engine.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_bridge_params.svh"

module axi_read_engine
    import axi_bridge_pkg::*;
(
    input  wire          aclk,
    input  wire          aresetn,
    input  wire rd_cmd_t rd_cmd,
    input  wire          rd_cmd_valid,
    output logic         rd_idle,
    output axi_ar_t      ar,
    output logic         arvalid,
    input  wire          arready,
    input  wire axi_r_t  r,
    input  wire          rvalid,
    output logic         rready,
    output rd_resp_t     rd_resp,
    output logic         rd_done
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ADDR = 2'd1;   // ar presented
    localparam logic [1:0] ST_DATA = 2'd2;   // waiting on the r beat

    logic [1:0] state;
    rd_cmd_t    cmd_q;

    assign rd_idle = state == ST_IDLE;

    //////////////////////////////
    // state machine

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rd_cmd_valid) begin
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (arready) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (rvalid) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // command held for the whole transfer
    always_ff @(posedge aclk) begin
        if (rd_idle && rd_cmd_valid) begin
            cmd_q <= rd_cmd;
        end
    end

    //////////////////////////////
    // channel outputs

    assign arvalid = state == ST_ADDR;
    assign ar.id   = cmd_q.id;
    assign ar.addr = cmd_q.addr;
    assign ar.size = cmd_q.size;

    assign rready  = state == ST_DATA;
    assign rd_done = rvalid && rready;

    // single beat, the returned id picks the port
    assign rd_resp.id   = r.id;
    assign rd_resp.data = r.data;

endmodule

`default_nettype wire

/* hdl/axi_write_engine.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_bridge_params.svh"

module axi_write_engine
    import axi_bridge_pkg::*;
(
    input  wire                    aclk,
    input  wire                    aresetn,
    input  wire wr_cmd_t           wr_cmd,
    input  wire                    wr_cmd_valid,
    output logic                   wr_idle,
    output logic [`AXI_ADDR_W-1:0] wr_pend_addr,
    output axi_aw_t                aw,
    output logic                   awvalid,
    input  wire                    awready,
    output axi_w_t                 w,
    output logic                   wvalid,
    input  wire                    wready,
    input  wire axi_b_t            b,
    input  wire                    bvalid,
    output logic                   bready,
    output logic                   wr_done
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_SEND = 2'd1;   // aw and w in flight
    localparam logic [1:0] ST_RESP = 2'd2;   // waiting on b

    logic [1:0] state;
    logic       aw_done;
    logic       w_done;
    logic       aw_hs;
    logic       w_hs;
    logic       aw_fin;
    logic       w_fin;
    wr_cmd_t    cmd_q;

    assign aw_hs  = awvalid && awready;
    assign w_hs   = wvalid && wready;
    assign aw_fin = aw_done || aw_hs;
    assign w_fin  = w_done || w_hs;

    assign wr_idle = state == ST_IDLE;

    //////////////////////////////
    // state machine

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state   <= ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (wr_cmd_valid) begin
                        state <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    // aw and w may finish in either order
                    aw_done <= aw_fin;
                    w_done  <= w_fin;
                    if (aw_fin && w_fin) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (bvalid) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_idle && wr_cmd_valid) begin
            cmd_q <= wr_cmd;
        end
    end

    //////////////////////////////
    // channel outputs

    assign awvalid = state == ST_SEND && !aw_done;
    assign aw.addr = cmd_q.addr;
    assign aw.size = cmd_q.size;

    assign wvalid  = state == ST_SEND && !w_done;
    assign w.data  = cmd_q.wdata;
    assign w.strb  = cmd_q.wstrb;

    assign bready  = state == ST_RESP;
    assign wr_done = bvalid && bready;   // b.resp is always OKAY from this slave

    assign wr_pend_addr = cmd_q.addr;   // read hazard compare

endmodule

`default_nettype wire

/* hdl/sram_resp_router.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_bridge_params.svh"

module sram_resp_router
    import axi_bridge_pkg::*;
(
    input  wire                    aclk,
    input  wire                    aresetn,
    input  wire rd_resp_t          rd_resp,
    input  wire                    rd_done,
    input  wire                    wr_done,
    output logic [`AXI_DATA_W-1:0] inst_rdata,
    output logic                   inst_data_ok,
    output logic [`AXI_DATA_W-1:0] data_rdata,
    output logic                   data_data_ok
);

    logic rd_is_inst;
    logic rd_is_data;
    logic data_ok_owed;   // read and write finished together

    assign rd_is_inst = rd_resp.id == `AXI_ID_W'(`ID_INST);
    assign rd_is_data = rd_resp.id == `AXI_ID_W'(`ID_DATA);

    // one buffer per id, held until that id reads again
    always_ff @(posedge aclk) begin
        if (rd_done && rd_is_inst) begin
            inst_rdata <= rd_resp.data;
        end
        if (rd_done && rd_is_data) begin
            data_rdata <= rd_resp.data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            inst_data_ok <= 1'b0;
            data_data_ok <= 1'b0;
            data_ok_owed <= 1'b0;
        end else begin
            inst_data_ok <= rd_done && rd_is_inst;
            data_data_ok <= (rd_done && rd_is_data) || wr_done || data_ok_owed;
            data_ok_owed <= rd_done && rd_is_data && wr_done;   // second pulse next cycle
        end
    end

endmodule

`default_nettype wire

/* hdl/axi_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_bridge_params.svh"

module axi_bridge_top
    import axi_bridge_pkg::*;
(
    input  wire                    aclk,
    input  wire                    aresetn,
    // instruction port
    input  wire                    inst_req,
    input  wire sram_req_t         inst_req_info,
    output logic                   inst_addr_ok,
    output logic                   inst_data_ok,
    output logic [`AXI_DATA_W-1:0] inst_rdata,
    // data port
    input  wire                    data_req,
    input  wire sram_req_t         data_req_info,
    output logic                   data_addr_ok,
    output logic                   data_data_ok,
    output logic [`AXI_DATA_W-1:0] data_rdata,
    // axi master
    output axi_ar_t                ar,
    output logic                   arvalid,
    input  wire                    arready,
    input  wire axi_r_t            r,
    input  wire                    rvalid,
    output logic                   rready,
    output axi_aw_t                aw,
    output logic                   awvalid,
    input  wire                    awready,
    output axi_w_t                 w,
    output logic                   wvalid,
    input  wire                    wready,
    input  wire axi_b_t            b,
    input  wire                    bvalid,
    output logic                   bready
);

    rd_cmd_t                  rd_cmd;
    logic                     rd_cmd_valid;
    logic                     rd_idle;
    wr_cmd_t                  wr_cmd;
    logic                     wr_cmd_valid;
    logic                     wr_idle;
    logic [`AXI_ADDR_W-1:0]   wr_pend_addr;
    rd_resp_t                 rd_resp;
    logic                     rd_done;
    logic                     wr_done;

    //////////////////////////////
    // decode

    sram_req_arbiter sram_req_arbiter_inst (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .inst_req      (inst_req),
        .inst_req_info (inst_req_info),
        .data_req      (data_req),
        .data_req_info (data_req_info),
        .rd_idle       (rd_idle),
        .wr_idle       (wr_idle),
        .wr_pend_addr  (wr_pend_addr),
        .rd_cmd        (rd_cmd),
        .rd_cmd_valid  (rd_cmd_valid),
        .wr_cmd        (wr_cmd),
        .wr_cmd_valid  (wr_cmd_valid),
        .inst_addr_ok  (inst_addr_ok),
        .data_addr_ok  (data_addr_ok)
    );

    //////////////////////////////
    // execute

    axi_read_engine axi_read_engine_inst (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .rd_cmd       (rd_cmd),
        .rd_cmd_valid (rd_cmd_valid),
        .rd_idle      (rd_idle),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready),
        .rd_resp      (rd_resp),
        .rd_done      (rd_done)
    );

    axi_write_engine axi_write_engine_inst (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .wr_cmd       (wr_cmd),
        .wr_cmd_valid (wr_cmd_valid),
        .wr_idle      (wr_idle),
        .wr_pend_addr (wr_pend_addr),
        .aw           (aw),
        .awvalid      (awvalid),
        .awready      (awready),
        .w            (w),
        .wvalid       (wvalid),
        .wready       (wready),
        .b            (b),
        .bvalid       (bvalid),
        .bready       (bready),
        .wr_done      (wr_done)
    );

    //////////////////////////////
    // results back to the ports

    sram_resp_router sram_resp_router_inst (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .rd_resp      (rd_resp),
        .rd_done      (rd_done),
        .wr_done      (wr_done),
        .inst_rdata   (inst_rdata),
        .inst_data_ok (inst_data_ok),
        .data_rdata   (data_rdata),
        .data_data_ok (data_data_ok)
    );

endmodule

`default_nettype wire

/* verification/axi_bridge_assertions.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_bridge_params.svh"

module axi_bridge_assertions
    import axi_bridge_pkg::*;
(
    input wire          aclk,
    input wire          aresetn,
    input wire axi_ar_t ar,
    input wire          arvalid,
    input wire          arready,
    input wire axi_aw_t aw,
    input wire          awvalid,
    input wire          awready,
    input wire axi_w_t  w,
    input wire          wvalid,
    input wire          wready,
    input wire          rvalid,
    input wire          rready,
    input wire          bvalid,
    input wire          bready
);

    int unsigned fail_count = 0;   // polled by the testbench
    logic        rd_open;          // ar taken, r beat still due
    logic        aw_seen;
    logic        w_seen;

    //////////////////////////////
    // open transfers as seen on the bus

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rd_open <= 1'b0;
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                rd_open <= 1'b1;
            end else if (rvalid && rready) begin
                rd_open <= 1'b0;
            end
            if (bvalid && bready) begin
                aw_seen <= 1'b0;
                w_seen  <= 1'b0;
            end else begin
                if (awvalid && awready) begin
                    aw_seen <= 1'b1;
                end
                if (wvalid && wready) begin
                    w_seen <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // valid held with stable payload until ready

    ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            fail_count++;
            $error("arvalid dropped or ar changed before arready");
        end

    aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        awvalid && !awready |=> awvalid && $stable(aw))
        else begin
            fail_count++;
            $error("awvalid dropped or aw changed before awready");
        end

    w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        wvalid && !wready |=> wvalid && $stable(w))
        else begin
            fail_count++;
            $error("wvalid dropped or w changed before wready");
        end

    // ready only inside an open transfer
    rready_busy: assert property (@(posedge aclk) disable iff (!aresetn)
        rready |-> rd_open)
        else begin
            fail_count++;
            $error("rready high with no read address accepted");
        end

    bready_busy: assert property (@(posedge aclk) disable iff (!aresetn)
        bready |-> aw_seen && w_seen)
        else begin
            fail_count++;
            $error("bready high before both aw and w were accepted");
        end

endmodule

bind axi_bridge_top axi_bridge_assertions axi_bridge_assertions_inst (.*);

`default_nettype wire

/* verification/axi_bridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_bridge_params.svh"

module axi_bridge_tb
    import axi_bridge_pkg::*;
();

    logic                   aclk;
    logic                   aresetn;
    logic                   inst_req;
    sram_req_t              inst_req_info;
    logic                   inst_addr_ok;
    logic                   inst_data_ok;
    logic [`AXI_DATA_W-1:0] inst_rdata;
    logic                   data_req;
    sram_req_t              data_req_info;
    logic                   data_addr_ok;
    logic                   data_data_ok;
    logic [`AXI_DATA_W-1:0] data_rdata;
    axi_ar_t                ar;
    logic                   arvalid;
    logic                   arready;
    axi_r_t                 r;
    logic                   rvalid;
    logic                   rready;
    axi_aw_t                aw;
    logic                   awvalid;
    logic                   awready;
    axi_w_t                 w;
    logic                   wvalid;
    logic                   wready;
    axi_b_t                 b;
    logic                   bvalid;
    logic                   bready;

    logic [`AXI_DATA_W-1:0] mem [0:255];      // slave side
    logic [`AXI_DATA_W-1:0] shadow [0:255];   // expected contents
    logic [31:0]            lcg_state = 32'h6094_8410;
    int                     issued = 0;
    int                     inst_ok_count = 0;
    axi_ar_t                ar_q;
    axi_aw_t                aw_q;
    axi_w_t                 w_q;
    axi_b_t                 last_b;           // last b taken by the bridge

    axi_bridge_top axi_bridge_top_inst (.*);

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    //////////////////////////////
    // helpers

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned pick_delay();
        logic [31:0] v;
        v = lcg_next();
        return {30'd0, v[17:16]};   // 0 to 3 cycles
    endfunction

    function automatic logic [31:0] fill_word(input int unsigned i);
        return (i * 32'h0101_0101) ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [`AXI_DATA_W-1:0] exp_read(input logic [31:0] addr);
        return shadow[addr[9:2]];
    endfunction

    // ends 1 ns after the n-th rising edge, or at once for n of 0
    task automatic wait_cycles(input int unsigned n);
        repeat (n) begin
            @(posedge aclk);
            #1;
        end
    endtask

    task automatic stop_with_failure();
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_rdata(input logic [`AXI_DATA_W-1:0] got,
                               input logic [`AXI_DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_resp(input axi_b_t got, input axi_b_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: write resp %b expected %b", $time, got.resp, exp.resp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %b expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    //////////////////////////////
    // AXI slave model, drives 1 ns after a rising edge

    initial begin : read_slave
        wait (aresetn === 1'b1);
        forever begin
            @(posedge aclk);
            #1;
            if (arvalid) begin
                ar_q = ar;   // held until arready
                check_flag(ar_q.size == 3'd2, 1'b1, "ar size is one word");
                wait_cycles(pick_delay());
                arready = 1'b1;
                @(posedge aclk);
                #1 arready = 1'b0;
                wait_cycles(pick_delay());
                rvalid = 1'b1;
                r = '{id: ar_q.id, data: mem[ar_q.addr[9:2]], resp: 2'b00};
                while (!rready) begin
                    @(posedge aclk);
                    #1;
                end
                @(posedge aclk);
                #1 rvalid = 1'b0;
            end
        end
    end

    initial begin : write_slave
        wait (aresetn === 1'b1);
        forever begin
            @(posedge aclk);
            #1;
            if (awvalid || wvalid) begin
                fork
                    begin
                        aw_q = aw;
                        check_flag(aw_q.size == 3'd2, 1'b1, "aw size is one word");
                        wait_cycles(pick_delay());
                        awready = 1'b1;
                        @(posedge aclk);
                        #1 awready = 1'b0;
                    end
                    begin
                        w_q = w;
                        wait_cycles(pick_delay());
                        wready = 1'b1;
                        @(posedge aclk);
                        #1 wready = 1'b0;
                    end
                join
                for (int k = 0; k < 4; k++) begin
                    if (w_q.strb[k]) mem[aw_q.addr[9:2]][8*k +: 8] = w_q.data[8*k +: 8];
                end
                wait_cycles(pick_delay());
                bvalid = 1'b1;
                b = '{resp: 2'b00};
                while (!bready) begin
                    @(posedge aclk);
                    #1;
                end
                @(posedge aclk);
                #1 bvalid = 1'b0;
            end
        end
    end

    //////////////////////////////
    // monitors and watchdog

    initial begin : resp_monitor
        wait (aresetn === 1'b1);
        forever begin
            @(negedge aclk);
            if (bvalid && bready) last_b = b;
            if (inst_data_ok) inst_ok_count++;
            if (axi_bridge_top_inst.axi_bridge_assertions_inst.fail_count != 0) begin
                $display("a bus protocol assertion failed");
                stop_with_failure();
            end
        end
    end

    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        forever begin
            @(posedge aclk);
            cycles++;
            if (cycles > 200 * (issued + 1)) begin
                $display("timeout: the bridge stopped making progress after %0d cycles", cycles);
                stop_with_failure();
            end
        end
    end

    //////////////////////////////
    // port drivers, entered 1 ns after a rising edge

    task automatic inst_read(input logic [31:0] addr, output time ok_t);
        issued++;
        inst_req      = 1'b1;
        inst_req_info = '{wr: 1'b0, size: 2'd2, addr: addr, wstrb: '0, wdata: '0};
        @(negedge aclk);
        while (!inst_addr_ok) @(negedge aclk);
        ok_t = $time;
        @(posedge aclk);
        #1 inst_req = 1'b0;
        @(negedge aclk);
        while (!inst_data_ok) @(negedge aclk);
        check_rdata(inst_rdata, exp_read(addr), "inst port read");
        @(posedge aclk);
        #1;
    endtask

    task automatic data_access(input logic wr, input logic [31:0] addr,
                               input logic [3:0] strb, input logic [31:0] wdata,
                               output time ok_t, output time done_t);
        issued++;
        if (wr) begin
            last_b = '{resp: 2'b11};   // stays so unless a b is taken
        end
        data_req      = 1'b1;
        data_req_info = '{wr: wr, size: 2'd2, addr: addr, wstrb: strb, wdata: wdata};
        @(negedge aclk);
        while (!data_addr_ok) @(negedge aclk);
        ok_t = $time;
        @(posedge aclk);
        #1 data_req = 1'b0;
        @(negedge aclk);
        while (!data_data_ok) @(negedge aclk);
        done_t = $time;
        if (wr) begin
            check_resp(last_b, '{resp: 2'b00});
            for (int k = 0; k < 4; k++) begin
                if (strb[k]) shadow[addr[9:2]][8*k +: 8] = wdata[8*k +: 8];
            end
        end else begin
            check_rdata(data_rdata, exp_read(addr), "data port read");
        end
        @(posedge aclk);
        #1;
    endtask

    //////////////////////////////
    // stimulus

    initial begin : stimulus
        time t_inst;
        time t_data;
        time t_done;
        logic [31:0] v;
        aresetn = 1'b0;
        inst_req = 1'b0;
        inst_req_info = '0;
        data_req = 1'b0;
        data_req_info = '0;
        arready = 1'b0;
        r = '0;
        rvalid = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        b = '0;
        bvalid = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i]    = fill_word(i);
            shadow[i] = fill_word(i);
        end
        repeat (3) @(posedge aclk);
        #1 aresetn = 1'b1;

        // quiet bus after reset, then a single fetch
        @(negedge aclk);
        check_flag(arvalid | awvalid | wvalid | rready | bready, 1'b0, "axi valid/ready");
        check_flag(inst_addr_ok | data_addr_ok | inst_data_ok | data_data_ok, 1'b0, "port ok");
        @(posedge aclk);
        #1 inst_read(32'h0000_0010, t_inst);
        repeat (5) @(posedge aclk);
        #1 check_flag(inst_ok_count == 1, 1'b1, "single inst_data_ok");

        // partial write then read back
        data_access(1'b1, 32'h0000_0200, 4'b0110, 32'hdead_beef, t_data, t_done);
        data_access(1'b0, 32'h0000_0200, 4'b0000, 32'h0, t_data, t_done);

        // both ports read at once
        fork
            inst_read(32'h0000_0044, t_inst);
            data_access(1'b0, 32'h0000_0088, 4'b0000, 32'h0, t_data, t_done);
        join
        check_flag(t_inst < t_data, 1'b1, "inst read granted first");

        // read behind an in-flight write to the same word
        fork
            data_access(1'b1, 32'h0000_0300, 4'b1111, 32'h1234_5678, t_data, t_done);
            begin
                @(negedge aclk);
                while (!data_addr_ok) @(negedge aclk);
                @(posedge aclk);
                #1 inst_read(32'h0000_0300, t_inst);
            end
        join
        check_flag(t_inst >= t_done, 1'b1, "read held until write done");

        // random mix, inst reads stay below the written region
        fork
            for (int i = 0; i < 80; i++) begin
                v = lcg_next();
                repeat (v[1:0]) @(posedge aclk);
                if (v[1:0] != 2'd0) #1;
                inst_read({22'd0, 1'b0, v[14:8], 2'b00}, t_inst);
            end
            for (int i = 0; i < 120; i++) begin : data_side
                logic [31:0] u;
                logic [31:0] d;
                u = lcg_next();
                d = lcg_next();
                repeat (u[1:0]) @(posedge aclk);
                if (u[1:0] != 2'd0) #1;
                if (u[20])
                    data_access(1'b1, {22'd0, 1'b1, u[14:8], 2'b00},
                                u[27:24] | 4'b0001, d, t_data, t_done);
                else
                    data_access(1'b0, {22'd0, u[15:8], 2'b00}, 4'b0000, 32'h0,
                                t_data, t_done);
            end
        join

        repeat (5) @(negedge aclk);
        if (axi_bridge_top_inst.axi_bridge_assertions_inst.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("a bus protocol assertion failed near the end of the run");
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

/* axi_bridge_top.f */
+incdir+hdl
hdl/axi_bridge_pkg.sv
hdl/sram_req_arbiter.sv
hdl/axi_read_engine.sv
hdl/axi_write_engine.sv
hdl/sram_resp_router.sv
hdl/axi_bridge_top.sv
verification/axi_bridge_assertions.sv
verification/axi_bridge_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= axi_bridge_tb
FILELIST  ?= axi_bridge_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
